// ==== logic/axi_ic_pkg.sv ====
package axi_ic_pkg;

    parameter int NUM_MASTERS = 4;
    parameter int NUM_SLAVES  = 4;

    parameter int ADDR_W = 32;
    parameter int DATA_W = 32;
    parameter int LEN_W  = 8;
    parameter int MID_W  = 2;                         // id width on the master side
    parameter int IDX_W  = 2;                         // master or slave index
    parameter int SID_W  = IDX_W + MID_W;             // id width on the slave side

    typedef logic [ADDR_W-1:0] addr_t;
    typedef logic [LEN_W-1:0]  len_t;
    typedef logic [DATA_W-1:0] data_t;
    typedef logic [MID_W-1:0]  mid_t;
    typedef logic [IDX_W-1:0]  port_idx_t;

    // region bounds, entry i belongs to slave i
    typedef addr_t [NUM_SLAVES-1:0] region_tbl_t;

    typedef struct packed {
        port_idx_t midx;                              // issuing master
        mid_t      mid;                               // id as the master sent it
    } sid_fields_t;

    // opaque to slaves, decoded by the interconnect
    typedef union packed {
        logic [SID_W-1:0] raw;
        sid_fields_t      fields;
    } slave_id_u;

    typedef struct packed {
        addr_t addr;
        len_t  len;
        mid_t  id;
    } m_rd_req_t;

    typedef struct packed {
        addr_t     addr;
        len_t      len;
        slave_id_u id;
    } s_rd_req_t;

    typedef struct packed {
        data_t     data;
        logic      last;
        slave_id_u id;
    } s_rd_beat_t;

    typedef struct packed {
        data_t data;
        logic  last;
        mid_t  id;
    } m_rd_beat_t;

    // lowest set bit wins, zero when nothing is set
    function automatic port_idx_t first_set(input logic [NUM_MASTERS-1:0] vec);
        port_idx_t idx;
        idx = '0;
        for (int i = NUM_MASTERS - 1; i >= 0; i--) begin
            if (vec[i]) begin
                idx = port_idx_t'(i);
            end
        end
        return idx;
    endfunction

endpackage

// ==== logic/rd_addr_arbiter.sv ====
module rd_addr_arbiter (
    input  logic                                              BUS_CLK,
    input  logic                                              BUS_RST,

    input  axi_ic_pkg::m_rd_req_t [axi_ic_pkg::NUM_MASTERS-1:0] m_req,
    input  logic                  [axi_ic_pkg::NUM_MASTERS-1:0] m_arvalid,
    output logic                  [axi_ic_pkg::NUM_MASTERS-1:0] m_arready,

    output axi_ic_pkg::m_rd_req_t                             sel_req,
    output logic                                              sel_valid,
    output axi_ic_pkg::port_idx_t                             grant,
    input  logic                                              sel_ready
);

    logic                  lock;
    axi_ic_pkg::port_idx_t grant_q;
    axi_ic_pkg::port_idx_t prio_idx;

    assign prio_idx = axi_ic_pkg::first_set(m_arvalid);   // master 0 first

    // grant follows valids combinationally until the request has been shown
    assign grant = lock ? grant_q : prio_idx;

    assign sel_req   = m_req[grant];
    assign sel_valid = m_arvalid[grant];

    always_comb begin
        m_arready        = '0;
        m_arready[grant] = sel_valid & sel_ready;     // only the granted master
    end

    always_ff @(posedge BUS_CLK) begin
        if (BUS_RST) begin
            lock    <= 1'b0;
            grant_q <= '0;
        end else begin
            grant_q <= grant;
            if (sel_valid && sel_ready) begin
                lock <= 1'b0;                         // handshake done
            end else if (sel_valid) begin
                lock <= 1'b1;                         // stalled, keep this master
            end
        end
    end

    // a shown request stays put until the slave takes it
    a_addr_hold: assert property (
        @(posedge BUS_CLK) disable iff (BUS_RST)
        sel_valid && !sel_ready |=> sel_valid && $stable(grant) && $stable(sel_req)
    ) else $error("read address changed before the slave accepted it");

endmodule

// ==== logic/rd_addr_decoder.sv ====
module rd_addr_decoder #(
    parameter axi_ic_pkg::region_tbl_t S_BASE = '0,
    parameter axi_ic_pkg::region_tbl_t S_LAST = '0
) (
    input  axi_ic_pkg::m_rd_req_t                        sel_req,
    input  logic                                         sel_valid,
    input  axi_ic_pkg::port_idx_t                        grant,
    output logic                                         sel_ready,

    output axi_ic_pkg::s_rd_req_t                        s_req,
    output logic [axi_ic_pkg::NUM_SLAVES-1:0]            s_arvalid,
    input  logic [axi_ic_pkg::NUM_SLAVES-1:0]            s_arready
);

    axi_ic_pkg::port_idx_t slave_sel;
    axi_ic_pkg::slave_id_u sid;

    // inclusive ranges, walked from the top so the lowest slave wins an overlap
    always_comb begin
        slave_sel = '0;                               // unmapped goes to slave 0
        for (int i = axi_ic_pkg::NUM_SLAVES - 1; i >= 0; i--) begin
            if (sel_req.addr >= S_BASE[i] && sel_req.addr <= S_LAST[i]) begin
                slave_sel = axi_ic_pkg::port_idx_t'(i);
            end
        end
    end

    // master index on top so the data path can find its way back
    always_comb begin
        sid.fields.midx = grant;
        sid.fields.mid  = sel_req.id;
    end

    assign s_req = '{
        addr: sel_req.addr,
        len:  sel_req.len,
        id:   sid
    };

    always_comb begin
        s_arvalid            = '0;
        s_arvalid[slave_sel] = sel_valid;
    end

    assign sel_ready = s_arready[slave_sel];

endmodule

// ==== logic/rd_data_return.sv ====
module rd_data_return (
    input  logic                                                BUS_CLK,
    input  logic                                                BUS_RST,

    input  axi_ic_pkg::s_rd_beat_t [axi_ic_pkg::NUM_SLAVES-1:0]  s_beat,
    input  logic                   [axi_ic_pkg::NUM_SLAVES-1:0]  s_rvalid,
    output logic                   [axi_ic_pkg::NUM_SLAVES-1:0]  s_rready,

    output axi_ic_pkg::m_rd_beat_t [axi_ic_pkg::NUM_MASTERS-1:0] m_beat,
    output logic                   [axi_ic_pkg::NUM_MASTERS-1:0] m_rvalid,
    input  logic                   [axi_ic_pkg::NUM_MASTERS-1:0] m_rready
);

    logic                   lock;
    axi_ic_pkg::port_idx_t  sel_q;
    axi_ic_pkg::port_idx_t  sel;
    axi_ic_pkg::port_idx_t  dest;
    axi_ic_pkg::s_rd_beat_t beat;
    logic                   beat_valid;
    logic                   beat_ready;

    // slave 0 first, held for a whole burst once started
    assign sel = lock ? sel_q : axi_ic_pkg::first_set(s_rvalid);

    assign beat       = s_beat[sel];
    assign beat_valid = s_rvalid[sel];

    // upper id bits name the master that issued the request
    assign dest       = beat.id.fields.midx;
    assign beat_ready = m_rready[dest];

    always_comb begin
        m_rvalid       = '0;
        m_rvalid[dest] = beat_valid;
    end

    always_comb begin
        s_rready      = '0;
        s_rready[sel] = beat_valid & beat_ready;     // back-pressure from that master only
    end

    // payload goes to everyone, valid tells who owns it
    always_comb begin
        for (int i = 0; i < axi_ic_pkg::NUM_MASTERS; i++) begin
            m_beat[i].data = beat.data;
            m_beat[i].last = beat.last;
            m_beat[i].id   = beat.id.fields.mid;      // master sees its own id
        end
    end

    always_ff @(posedge BUS_CLK) begin
        if (BUS_RST) begin
            lock  <= 1'b0;
            sel_q <= '0;
        end else begin
            sel_q <= sel;
            if (beat_valid && beat_ready && beat.last) begin
                lock <= 1'b0;                         // burst finished
            end else if (beat_valid) begin
                lock <= 1'b1;
            end
        end
    end

    // a stalled beat must reach the same master next cycle
    a_dest_hold: assert property (
        @(posedge BUS_CLK) disable iff (BUS_RST)
        beat_valid && !beat_ready |=> beat_valid && $stable(dest)
    ) else $error("stalled read beat dropped or rerouted");

endmodule

// ==== logic/axi_ic_top.sv ====
module axi_ic_top #(
    parameter axi_ic_pkg::region_tbl_t S_BASE = {
        32'h3000_0000,
        32'h2000_0000,
        32'h1000_0000,
        32'h0000_0000
    },
    parameter axi_ic_pkg::region_tbl_t S_LAST = {
        32'h3FFF_FFFF,
        32'h2FFF_FFFF,
        32'h1FFF_FFFF,
        32'h0FFF_FFFF
    }
) (
    input  logic                                                BUS_CLK,
    input  logic                                                BUS_RST,

    // master side
    input  axi_ic_pkg::m_rd_req_t  [axi_ic_pkg::NUM_MASTERS-1:0] m_req,
    input  logic                   [axi_ic_pkg::NUM_MASTERS-1:0] m_arvalid,
    output logic                   [axi_ic_pkg::NUM_MASTERS-1:0] m_arready,
    output axi_ic_pkg::m_rd_beat_t [axi_ic_pkg::NUM_MASTERS-1:0] m_beat,
    output logic                   [axi_ic_pkg::NUM_MASTERS-1:0] m_rvalid,
    input  logic                   [axi_ic_pkg::NUM_MASTERS-1:0] m_rready,

    // slave side, request is shared and only the valids are steered
    output axi_ic_pkg::s_rd_req_t                                s_req,
    output logic                   [axi_ic_pkg::NUM_SLAVES-1:0]  s_arvalid,
    input  logic                   [axi_ic_pkg::NUM_SLAVES-1:0]  s_arready,
    input  axi_ic_pkg::s_rd_beat_t [axi_ic_pkg::NUM_SLAVES-1:0]  s_beat,
    input  logic                   [axi_ic_pkg::NUM_SLAVES-1:0]  s_rvalid,
    output logic                   [axi_ic_pkg::NUM_SLAVES-1:0]  s_rready
);

    axi_ic_pkg::m_rd_req_t sel_req;
    logic                  sel_valid;
    logic                  sel_ready;
    axi_ic_pkg::port_idx_t grant;

    rd_addr_arbiter rd_addr_arbiter_i (
        .BUS_CLK   (BUS_CLK),
        .BUS_RST   (BUS_RST),
        .m_req     (m_req),
        .m_arvalid (m_arvalid),
        .m_arready (m_arready),
        .sel_req   (sel_req),
        .sel_valid (sel_valid),
        .grant     (grant),
        .sel_ready (sel_ready)
    );

    rd_addr_decoder #(
        .S_BASE (S_BASE),
        .S_LAST (S_LAST)
    ) rd_addr_decoder_i (
        .sel_req   (sel_req),
        .sel_valid (sel_valid),
        .grant     (grant),
        .sel_ready (sel_ready),
        .s_req     (s_req),
        .s_arvalid (s_arvalid),
        .s_arready (s_arready)
    );

    // read data runs independently of the address path
    rd_data_return rd_data_return_i (
        .BUS_CLK  (BUS_CLK),
        .BUS_RST  (BUS_RST),
        .s_beat   (s_beat),
        .s_rvalid (s_rvalid),
        .s_rready (s_rready),
        .m_beat   (m_beat),
        .m_rvalid (m_rvalid),
        .m_rready (m_rready)
    );

endmodule

// ==== test/tb_axi_ic_tasks.svh ====
// drive point is one unit past the rising edge
task automatic tick();
    @(posedge BUS_CLK);
    #1;
endtask

task automatic hold_cycle();
    tick();
    #1;                                           // back to the sample point
endtask

task automatic check_req(input string name, input axi_ic_pkg::s_rd_req_t got,
                         input axi_ic_pkg::s_rd_req_t want);
    if (got !== want) begin
        mismatch_count++;
        $display("MISMATCH %s: got %h, expected %h", name, got, want);
    end
endtask

task automatic check_beat(input string name, input axi_ic_pkg::m_rd_beat_t got,
                          input axi_ic_pkg::m_rd_beat_t want);
    if (got !== want) begin
        mismatch_count++;
        $display("MISMATCH %s: got %h, expected %h", name, got, want);
    end
endtask

task automatic check_idx(input string name, input axi_ic_pkg::port_idx_t got,
                         input axi_ic_pkg::port_idx_t want);
    if (got !== want) begin
        mismatch_count++;
        $display("MISMATCH %s: got %h, expected %h", name, got, want);
    end
endtask

task automatic check_bit(input string name, input logic got, input logic want);
    if (got !== want) begin
        mismatch_count++;
        $display("MISMATCH %s: got %h, expected %h", name, got, want);
    end
endtask

task automatic check_count(input string name, input int got, input int want);
    if (got != want) begin
        mismatch_count++;
        $display("MISMATCH %s: got %h, expected %h", name, got, want);
    end
endtask

task automatic wait_s_arvalid(input int s);
    int n;
    n = 0;
    while (!s_arvalid[s] && n < WAIT_LIMIT) begin
        hold_cycle();
        n++;
    end
    if (!s_arvalid[s]) begin
        timeout_count++;
        $display("timeout: slave %0d never saw its read request", s);
    end
endtask

task automatic wait_m_rvalid(input int m);
    int n;
    n = 0;
    while (!m_rvalid[m] && n < WAIT_LIMIT) begin
        hold_cycle();
        n++;
    end
    if (!m_rvalid[m]) begin
        timeout_count++;
        $display("timeout: master %0d never received a read beat", m);
    end
endtask

// region i covers i000_0000 to iFFF_FFFF, anything above 3FFF_FFFF is unmapped
function automatic axi_ic_pkg::port_idx_t region_of(input axi_ic_pkg::addr_t a);
    if (a[31:28] > 4'h3) begin
        return '0;
    end
    return axi_ic_pkg::port_idx_t'(a[29:28]);
endfunction

function automatic axi_ic_pkg::m_rd_req_t random_req(input axi_ic_pkg::port_idx_t region);
    axi_ic_pkg::m_rd_req_t r;
    logic [31:0]           rnd;
    rnd    = $random(seed);
    r.addr = {2'b00, region, rnd[27:0]};
    r.len  = axi_ic_pkg::len_t'($random(seed));
    r.id   = axi_ic_pkg::mid_t'($random(seed));
    return r;
endfunction

function automatic axi_ic_pkg::s_rd_req_t slave_view(input int m,
                                                     input axi_ic_pkg::m_rd_req_t r);
    axi_ic_pkg::s_rd_req_t s;
    s.addr   = r.addr;
    s.len    = r.len;
    s.id.raw = {axi_ic_pkg::port_idx_t'(m), r.id};   // master index on top
    return s;
endfunction

task automatic present_req(input int m, input axi_ic_pkg::m_rd_req_t r);
    m_req[m]     = r;
    m_arvalid[m] = 1'b1;
endtask

// request from master m must sit on its region's slave and nowhere else
task automatic expect_addr(input int m, input axi_ic_pkg::m_rd_req_t r);
    axi_ic_pkg::port_idx_t s;
    s = region_of(r.addr);
    wait_s_arvalid(s);
    for (int i = 0; i < 4; i++) begin
        check_bit($sformatf("s_arvalid[%0d]", i), s_arvalid[i],
                  axi_ic_pkg::port_idx_t'(i) == s);
    end
    check_req("s_req", s_req, slave_view(m, r));
endtask

task automatic finish_addr(input int m, input axi_ic_pkg::m_rd_req_t r);
    axi_ic_pkg::port_idx_t s;
    s = region_of(r.addr);
    tick();
    s_arready[s] = 1'b1;
    #1;
    for (int i = 0; i < 4; i++) begin
        check_bit($sformatf("m_arready[%0d]", i), m_arready[i], i == m);   // owner only
    end
    check_req("s_req", s_req, slave_view(m, r));
    tick();
    m_arvalid[m] = 1'b0;
    s_arready    = '0;
    #1;
endtask

// ==== test/tb_axi_ic.sv ====
module tb_axi_ic;

    localparam int WAIT_LIMIT = 20;
    localparam int WATCHDOG   = 20000;

    localparam axi_ic_pkg::region_tbl_t S_BASE = {
        32'h3000_0000, 32'h2000_0000, 32'h1000_0000, 32'h0000_0000
    };
    localparam axi_ic_pkg::region_tbl_t S_LAST = {
        32'h3FFF_FFFF, 32'h2FFF_FFFF, 32'h1FFF_FFFF, 32'h0FFF_FFFF
    };

    logic BUS_CLK = 1'b0;
    logic BUS_RST;

    axi_ic_pkg::m_rd_req_t  [3:0] m_req;
    logic                   [3:0] m_arvalid;
    logic                   [3:0] m_arready;
    axi_ic_pkg::m_rd_beat_t [3:0] m_beat;
    logic                   [3:0] m_rvalid;
    logic                   [3:0] m_rready;
    axi_ic_pkg::s_rd_req_t        s_req;
    logic                   [3:0] s_arvalid;
    logic                   [3:0] s_arready;
    axi_ic_pkg::s_rd_beat_t [3:0] s_beat;
    logic                   [3:0] s_rvalid;
    logic                   [3:0] s_rready;

    integer seed;
    int     mismatch_count;
    int     timeout_count;

    axi_ic_pkg::m_rd_beat_t acc_beat[$];              // beats taken by masters, in order
    axi_ic_pkg::port_idx_t  acc_dest[$];

    always #4 BUS_CLK = ~BUS_CLK;

    axi_ic_top #(
        .S_BASE (S_BASE),
        .S_LAST (S_LAST)
    ) axi_ic_top_i (
        .BUS_CLK   (BUS_CLK),
        .BUS_RST   (BUS_RST),
        .m_req     (m_req),
        .m_arvalid (m_arvalid),
        .m_arready (m_arready),
        .m_beat    (m_beat),
        .m_rvalid  (m_rvalid),
        .m_rready  (m_rready),
        .s_req     (s_req),
        .s_arvalid (s_arvalid),
        .s_arready (s_arready),
        .s_beat    (s_beat),
        .s_rvalid  (s_rvalid),
        .s_rready  (s_rready)
    );

    always @(posedge BUS_CLK) begin
        if (!BUS_RST) begin
            for (int i = 0; i < 4; i++) begin
                if (m_rvalid[i] && m_rready[i]) begin
                    acc_beat.push_back(m_beat[i]);
                    acc_dest.push_back(axi_ic_pkg::port_idx_t'(i));
                end
            end
        end
    end

    `include "tb_axi_ic_tasks.svh"

    task automatic reset_quiet();
        for (int i = 0; i < 4; i++) begin
            check_bit($sformatf("s_arvalid[%0d]", i), s_arvalid[i], 1'b0);
            check_bit($sformatf("m_arready[%0d]", i), m_arready[i], 1'b0);
            check_bit($sformatf("m_rvalid[%0d]", i), m_rvalid[i], 1'b0);
            check_bit($sformatf("s_rready[%0d]", i), s_rready[i], 1'b0);
        end
    endtask

    task automatic addr_routing();
        axi_ic_pkg::m_rd_req_t r;
        for (int m = 0; m < 4; m++) begin
            r = random_req(axi_ic_pkg::port_idx_t'((m + 1) % 4));
            tick();
            present_req(m, r);
            #1;
            expect_addr(m, r);
            finish_addr(m, r);
        end
        r      = random_req(2'd0);
        r.addr = 32'h4000_0010;                       // outside every region
        tick();
        present_req(2, r);
        #1;
        expect_addr(2, r);
        finish_addr(2, r);
    endtask

    task automatic addr_priority();
        axi_ic_pkg::m_rd_req_t r1;
        axi_ic_pkg::m_rd_req_t r3;
        r1 = random_req(2'd2);
        r3 = random_req(2'd1);
        tick();
        present_req(1, r1);
        present_req(3, r3);
        #1;
        expect_addr(1, r1);
        finish_addr(1, r1);
        expect_addr(3, r3);
        finish_addr(3, r3);
    endtask

    task automatic addr_lock_under_stall();
        axi_ic_pkg::m_rd_req_t r2;
        axi_ic_pkg::m_rd_req_t r0;
        r2 = random_req(2'd1);
        r0 = random_req(2'd3);
        tick();
        present_req(2, r2);
        #1;
        expect_addr(2, r2);
        tick();
        present_req(0, r0);                           // higher priority, arrives late
        #1;
        for (int i = 0; i < 3; i++) begin
            expect_addr(2, r2);
            hold_cycle();
        end
        finish_addr(2, r2);
        expect_addr(0, r0);
        finish_addr(0, r0);
    endtask

    task automatic data_routing();
        axi_ic_pkg::s_rd_beat_t b;
        axi_ic_pkg::m_rd_beat_t want;
        axi_ic_pkg::mid_t       j;
        int                     s;
        for (int k = 0; k < 4; k++) begin
            s        = 3 - k;
            j        = axi_ic_pkg::mid_t'($random(seed));
            b.data   = axi_ic_pkg::data_t'($random(seed));
            b.last   = 1'b1;
            b.id.raw = {axi_ic_pkg::port_idx_t'(k), j};
            want     = '{data: b.data, last: 1'b1, id: j};
            tick();
            s_beat[s]   = b;
            s_rvalid[s] = 1'b1;
            m_rready    = ~(4'b0001 << k);            // every master but k is ready
            #1;
            wait_m_rvalid(k);
            for (int i = 0; i < 4; i++) begin
                check_bit($sformatf("m_rvalid[%0d]", i), m_rvalid[i], i == k);
            end
            check_beat($sformatf("m_beat[%0d]", k), m_beat[k], want);
            for (int i = 0; i < 2; i++) begin
                check_bit($sformatf("s_rready[%0d]", s), s_rready[s], 1'b0);
                hold_cycle();
            end
            tick();
            m_rready[k] = 1'b1;
            #1;
            check_bit($sformatf("s_rready[%0d]", s), s_rready[s], 1'b1);
            tick();
            s_rvalid[s] = 1'b0;
            m_rready    = '0;
            #1;
            check_bit("m_rvalid any", |m_rvalid, 1'b0);
        end
    endtask

    task automatic burst_lock();
        axi_ic_pkg::s_rd_beat_t burst [3];
        axi_ic_pkg::s_rd_beat_t single;
        axi_ic_pkg::m_rd_beat_t want [4];
        axi_ic_pkg::mid_t       j2;
        axi_ic_pkg::mid_t       j0;
        j2 = axi_ic_pkg::mid_t'($random(seed));
        j0 = axi_ic_pkg::mid_t'($random(seed));
        for (int b = 0; b < 3; b++) begin
            burst[b].data   = axi_ic_pkg::data_t'($random(seed));
            burst[b].last   = (b == 2);
            burst[b].id.raw = {2'd1, j2};             // slave 2 answers master 1
            want[b]         = '{data: burst[b].data, last: burst[b].last, id: j2};
        end
        single.data   = axi_ic_pkg::data_t'($random(seed));
        single.last   = 1'b1;
        single.id.raw = {2'd3, j0};                   // slave 0 answers master 3
        want[3]       = '{data: single.data, last: 1'b1, id: j0};
        acc_beat.delete();
        acc_dest.delete();
        tick();
        m_rready = '1;
        for (int b = 0; b < 3; b++) begin
            if (b > 0) begin
                tick();
            end
            s_beat[2]   = burst[b];
            s_rvalid[2] = 1'b1;
            if (b == 1) begin
                s_beat[0]   = single;
                s_rvalid[0] = 1'b1;
            end
            #1;
            wait_m_rvalid(1);
            check_beat("m_beat[1]", m_beat[1], want[b]);
            check_bit("m_rvalid[3]", m_rvalid[3], 1'b0);
            check_bit("s_rready[0]", s_rready[0], 1'b0);
            check_bit("s_rready[2]", s_rready[2], 1'b1);
        end
        tick();
        s_rvalid[2] = 1'b0;
        #1;
        wait_m_rvalid(3);
        check_beat("m_beat[3]", m_beat[3], want[3]);
        tick();
        s_rvalid[0] = 1'b0;
        m_rready    = '0;
        #1;
        check_count("accepted beats", acc_beat.size(), 4);
        if (acc_beat.size() == 4) begin
            for (int b = 0; b < 4; b++) begin
                check_beat($sformatf("accepted beat %0d", b), acc_beat[b], want[b]);
                check_idx($sformatf("beat %0d master", b), acc_dest[b],
                          (b < 3) ? 2'd1 : 2'd3);
            end
        end
    endtask

    initial begin
        seed           = 99389;
        mismatch_count = 0;
        timeout_count  = 0;
        BUS_RST        = 1'b1;
        m_req          = '0;
        m_arvalid      = '0;
        m_rready       = '0;
        s_arready      = '0;
        s_beat         = '0;
        s_rvalid       = '0;
        repeat (3) @(posedge BUS_CLK);
        #1;
        BUS_RST = 1'b0;
        #1;
        reset_quiet();
        addr_routing();
        addr_priority();
        addr_lock_under_stall();
        data_routing();
        burst_lock();
        $display("errors: %0d mismatches, %0d timeouts", mismatch_count, timeout_count);
        if (mismatch_count == 0 && timeout_count == 0) begin
            $display("*** PASSED ***");
        end else begin
            $display("*** FAILED ***");
        end
        $finish;
    end

    initial begin
        #(WATCHDOG);
        $display("timeout: run did not finish within %0d time units", WATCHDOG);
        $display("*** FAILED ***");
        $finish;
    end

endmodule

// ==== compile.f ====
+incdir+test
logic/axi_ic_pkg.sv
logic/rd_addr_arbiter.sv
logic/rd_addr_decoder.sv
logic/rd_data_return.sv
logic/axi_ic_top.sv
test/tb_axi_ic.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= tb_axi_ic
FILELIST  ?= compile.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
PASS_MSG  ?= *** PASSED ***
VFLAGS    ?= --binary --timing --assert
EXTRA     ?=

SIM_BIN := $(BUILD_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) $(EXTRA) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)

run: compile
	$(SIM_BIN) > $(LOG) 2>&1; cat $(LOG)
	@if grep -qF '$(PASS_MSG)' $(LOG); then \
		echo "simulation passed"; \
	else \
		echo "simulation failed, see $(LOG)"; \
		exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)
